//--- Bender.yml
package:
  name: rv_pipeline

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/fetch_stage.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/memory_writeback.sv
      - verilog/hazard_unit.sv
      - verilog/rv_pipeline.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_pipeline.sv

//--- tb.f
+incdir+tests
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/hazard_unit.sv
verilog/rv_pipeline.sv
tests/tb_rv_pipeline.sv

//--- tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]     lfsr = 32'hbb29;
rv_pkg::word_t   mregs [32];
rv_pkg::word_t   mdm [64];
rv_pkg::retire_t exp_retire [$];
rv_pkg::store_t  exp_store [$];
rv_pkg::word_t   exp_load [$];
int              n_dep;
int              n_load_use;
int              n_taken;

// fibonacci lfsr on x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
endfunction

function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
        r = {r[30:0], lfsr_bit()};
    end
    return r;
endfunction

function automatic rv_pkg::word_t fill_word(int i);
    return 32'hc3a5_0000 ^ (32'h0001_0203 * i);
endfunction

function automatic rv_pkg::word_t enc_r(logic [6:0] f7, rv_pkg::reg_addr_t rs2,
                                        rv_pkg::reg_addr_t rs1, logic [2:0] f3,
                                        rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
endfunction

function automatic rv_pkg::word_t enc_i(logic [11:0] imm, rv_pkg::reg_addr_t rs1,
                                        logic [2:0] f3, rv_pkg::reg_addr_t rd,
                                        rv_pkg::opcode_e opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::word_t enc_s(logic [11:0] imm, rv_pkg::reg_addr_t rs2,
                                        rv_pkg::reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic rv_pkg::word_t enc_b(logic [12:0] off, rv_pkg::reg_addr_t rs2,
                                        rv_pkg::reg_addr_t rs1, logic ne);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic rv_pkg::word_t enc_j(logic [20:0] off, rv_pkg::reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
endfunction

task automatic model_write(rv_pkg::reg_addr_t rd, rv_pkg::word_t v);
    rv_pkg::retire_t e;
    if (rd != '0) begin
        mregs[rd] = v;
        e.rd      = rd;
        e.value   = v;
        exp_retire.push_back(e);
    end
endtask

// generates the program and runs the reference model alongside it
task automatic build_program();
    int                mpc;
    int                kind;
    int                span;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::reg_addr_t prev_rd;
    rv_pkg::word_t     a;
    rv_pkg::word_t     b;
    rv_pkg::word_t     res;
    rv_pkg::word_t     ea;
    rv_pkg::word_t     off;
    rv_pkg::store_t    st;
    logic [11:0]       imm;
    logic              wr;
    logic              is_ld;
    logic              is_st;
    logic              uses2;
    logic              taken;
    logic              prev_load;
    mpc        = 0;
    prev_rd    = '0;
    prev_load  = 1'b0;
    n_dep      = 0;
    n_load_use = 0;
    n_taken    = 0;
    for (int i = 0; i < 32; i++) begin
        mregs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        mdm[i] = fill_word(i);
    end
    for (int i = 0; i < 256; i++) begin
        imem[i] = 32'h0000_0013;
    end
    for (int i = 0; i < N_INSTR; i++) begin
        kind = int'(take_bits(4));
        rd   = rv_pkg::reg_addr_t'(take_bits(3));
        rs1  = rv_pkg::reg_addr_t'(take_bits(3));
        rs2  = rv_pkg::reg_addr_t'(take_bits(3));
        imm  = 12'(take_bits(12));
        span = int'(take_bits(2)) + 1;
        if (i + span > N_INSTR) begin
            span = N_INSTR - i;
        end
        // keep loads and stores inside the 64-word area
        if (kind >= 8 && kind <= 11) begin
            ea  = take_bits(6) << 2;
            off = ea - mregs[rs1];
            if ($signed(off) < -2048 || $signed(off) > 2047) begin
                rs1 = '0;
                off = ea;
            end
            imm = off[11:0];
        end
        a     = mregs[rs1];
        b     = mregs[rs2];
        ea    = a + {{20{imm[11]}}, imm};
        res   = '0;
        wr    = 1'b1;
        is_ld = 1'b0;
        is_st = 1'b0;
        uses2 = 1'b1;
        taken = 1'b0;
        case (kind)
            0, 1: begin
                imem[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
                res     = a + b;
            end
            2: begin
                imem[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
                res     = a - b;
            end
            3: begin
                imem[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                res     = a & b;
            end
            4: begin
                imem[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                res     = a | b;
            end
            5: begin
                imem[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
                res     = a ^ b;
            end
            8, 9: begin
                imem[i] = enc_i(imm, rs1, 3'b010, rd, rv_pkg::OPC_LOAD);
                res     = mdm[ea[7:2]];
                is_ld   = 1'b1;
                uses2   = 1'b0;
            end
            10, 11: begin
                imem[i] = enc_s(imm, rs2, rs1);
                wr      = 1'b0;
                is_st   = 1'b1;
            end
            12, 13: begin
                imem[i] = enc_b(13'(span * 4), rs2, rs1, kind == 13);
                wr      = 1'b0;
                taken   = (a == b) ^ (kind == 13);
            end
            14: begin
                imem[i] = enc_j(21'(span * 4), rd);
                res     = RESET_PC + rv_pkg::word_t'(4 * i + 4);
                uses2   = 1'b0;
                taken   = 1'b1;
            end
            default: begin
                imem[i] = enc_i(imm, rs1, 3'b000, rd, rv_pkg::OPC_OP_IMM);
                res     = a + {{20{imm[11]}}, imm};
                uses2   = 1'b0;
            end
        endcase
        if (mpc == i) begin
            // tally hazards against the previous executed instruction
            if (prev_rd != '0 && kind != 14 &&
                (rs1 == prev_rd || (uses2 && rs2 == prev_rd))) begin
                if (prev_load) begin
                    n_load_use++;
                end else begin
                    n_dep++;
                end
            end
            if (is_ld) begin
                exp_load.push_back(ea);
            end
            if (is_st) begin
                mdm[ea[7:2]] = b;
                st.addr      = ea;
                st.data      = b;
                exp_store.push_back(st);
            end
            if (wr) begin
                model_write(rd, res);
            end
            prev_rd   = wr ? rd : '0;
            prev_load = is_ld;
            if (taken) begin
                n_taken++;
                mpc = i + span;
            end else begin
                mpc = i + 1;
            end
        end
    end
    // parking loop at the end
    imem[N_INSTR] = enc_j(21'd0, 5'd0);
endtask

`endif

//--- tests/tb_rv_pipeline.sv
module tb_rv_pipeline;

    localparam int            N_INSTR  = 200;
    localparam rv_pkg::word_t RESET_PC = '0;
    localparam int            WATCHDOG = 8 * (4 * N_INSTR + 50);

    logic            clk;
    logic            rst;
    rv_pkg::word_t   instr;
    rv_pkg::word_t   pc;
    rv_pkg::word_t   read_data;
    rv_pkg::word_t   data_addr;
    rv_pkg::word_t   din;
    logic            data_we;
    logic            data_re;
    logic            retire_valid;
    rv_pkg::retire_t retire;
    rv_pkg::store_t  seen_store;

    rv_pkg::word_t   imem [256];
    rv_pkg::word_t   dmem [64];
    int              retire_errors;
    int              store_errors;
    int              load_errors;
    int              other_errors;
    int              post_cyc;

    `include "tb_model.svh"

    rv_pipeline #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .pc           (pc),
        .read_data    (read_data),
        .data_addr    (data_addr),
        .din          (din),
        .data_we      (data_we),
        .data_re      (data_re),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    // both memories answer combinationally
    assign instr     = imem[8'((pc - RESET_PC) >> 2)];
    assign read_data = dmem[data_addr[7:2]];

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (data_we === 1'b1) begin
            dmem[data_addr[7:2]] <= din;
        end
    end

    task automatic check_pc(input rv_pkg::word_t got);
        if (got !== RESET_PC) begin
            $display("mismatch at %0t: pc %h in the first cycle after reset, expected %h",
                     $time, got, RESET_PC);
            other_errors++;
        end
    endtask

    task automatic check_retire(input rv_pkg::retire_t got);
        rv_pkg::retire_t exp;
        if (exp_retire.size() == 0) begin
            $display("unexpected retire at %0t: x%0d written with %h after the last expected one",
                     $time, got.rd, got.value);
            retire_errors++;
        end else begin
            exp = exp_retire.pop_front();
            if (got !== exp) begin
                $display("mismatch at %0t: retire x%0d = %h, expected x%0d = %h",
                         $time, got.rd, got.value, exp.rd, exp.value);
                retire_errors++;
            end
        end
    endtask

    task automatic check_store(input rv_pkg::store_t got);
        rv_pkg::store_t exp;
        if (exp_store.size() == 0) begin
            $display("unexpected store at %0t: %h to address %h after the last expected one",
                     $time, got.data, got.addr);
            store_errors++;
        end else begin
            exp = exp_store.pop_front();
            if (got !== exp) begin
                $display("mismatch at %0t: store %h -> %h, expected %h -> %h",
                         $time, got.data, got.addr, exp.data, exp.addr);
                store_errors++;
            end
        end
    endtask

    task automatic check_load(input rv_pkg::word_t got);
        rv_pkg::word_t exp;
        if (exp_load.size() == 0) begin
            $display("unexpected load at %0t: address %h after the last expected one",
                     $time, got);
            load_errors++;
        end else begin
            exp = exp_load.pop_front();
            if (got !== exp) begin
                $display("mismatch at %0t: load address %h, expected %h", $time, got, exp);
                load_errors++;
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: retire %0d, store %0d, load %0d, other %0d",
                 retire_errors, store_errors, load_errors, other_errors);
        if (retire_errors + store_errors + load_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            if (post_cyc == 0) begin
                check_pc(pc);
            end
            if (post_cyc < 3 && (data_we !== 1'b0 || data_re !== 1'b0)) begin
                $display("data strobe active at %0t before any instruction reached memory",
                         $time);
                other_errors++;
            end
            if (post_cyc < 4 && retire_valid !== 1'b0) begin
                $display("retire_valid high at %0t before any instruction reached write-back",
                         $time);
                other_errors++;
            end
            if (retire_valid === 1'b1) begin
                check_retire(retire);
            end
            if (data_we === 1'b1) begin
                seen_store.addr = data_addr;
                seen_store.data = din;
                check_store(seen_store);
            end
            if (data_re === 1'b1) begin
                check_load(data_addr);
            end
            post_cyc++;
        end
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        retire_errors = 0;
        store_errors  = 0;
        load_errors   = 0;
        other_errors  = 0;
        post_cyc      = 0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i);
        end
        build_program();
        $display("program: %0d retires, %0d stores, %0d loads expected", exp_retire.size(),
                 exp_store.size(), exp_load.size());
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (exp_retire.size() != 0 || exp_store.size() != 0 || exp_load.size() != 0) begin
            @(posedge clk);
        end
        // the parking loop must stay silent
        repeat (20) @(posedge clk);
        $display("hazards seen: %0d back-to-back, %0d load-use, %0d taken transfers",
                 n_dep, n_load_use, n_taken);
        finish_run();
    end

    initial begin
        #(WATCHDOG);
        $display("timeout at %0t: queues not drained, %0d retires, %0d stores, %0d loads left",
                 $time, exp_retire.size(), exp_store.size(), exp_load.size());
        other_errors++;
        finish_run();
    end

endmodule

//--- verilog/decode_stage.sv
module decode_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::if_id_t    if_id,
    input  rv_pkg::wb_t       wb,
    input  logic              flush_e,
    output rv_pkg::id_ex_t    id_ex,
    output rv_pkg::reg_addr_t rs1_d,
    output rv_pkg::reg_addr_t rs2_d,
    output logic              use_rs2
);

    rv_pkg::word_t     regs [32];
    rv_pkg::word_t     ins;
    rv_pkg::opcode_e   opcode;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::id_ex_t    id_ex_d;

    assign ins    = if_id.instr;
    assign opcode = rv_pkg::opcode_e'(ins[6:0]);
    // jal has no source register
    assign rs1    = (opcode == rv_pkg::OPC_JAL) ? '0 : ins[19:15];
    assign rs2    = ins[24:20];

    // x0 is hardwired, write-back bypasses the array in the same cycle
    function automatic rv_pkg::word_t read_reg(rv_pkg::reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        if (wb.reg_write && wb.rd == a) begin
            return wb.result;
        end
        return regs[a];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        id_ex_d          = '0;
        id_ex_d.rd1      = read_reg(rs1);
        id_ex_d.rd2      = read_reg(rs2);
        id_ex_d.rs1      = rs1;
        id_ex_d.rs2      = rs2;
        id_ex_d.rd       = ins[11:7];
        id_ex_d.pc       = if_id.pc;
        id_ex_d.pc_plus4 = if_id.pc_plus4;
        id_ex_d.alu_op   = rv_pkg::ALU_ADD;
        use_rs2          = 1'b0;
        case (opcode)
            rv_pkg::OPC_OP: begin
                id_ex_d.reg_write = 1'b1;
                use_rs2           = 1'b1;
                case (ins[14:12])
                    3'b000:  id_ex_d.alu_op = ins[30] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'b100:  id_ex_d.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  id_ex_d.alu_op = rv_pkg::ALU_OR;
                    3'b111:  id_ex_d.alu_op = rv_pkg::ALU_AND;
                    default: id_ex_d.alu_op = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                id_ex_d.reg_write = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.imm       = {{20{ins[31]}}, ins[31:20]};
            end
            rv_pkg::OPC_LOAD: begin
                id_ex_d.reg_write  = 1'b1;
                id_ex_d.mem_read   = 1'b1;
                id_ex_d.alu_src    = 1'b1;
                id_ex_d.result_src = rv_pkg::RES_MEM;
                id_ex_d.imm        = {{20{ins[31]}}, ins[31:20]};
            end
            rv_pkg::OPC_STORE: begin
                id_ex_d.mem_write = 1'b1;
                id_ex_d.alu_src   = 1'b1;
                id_ex_d.imm       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                use_rs2           = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                id_ex_d.branch    = 1'b1;
                id_ex_d.branch_ne = ins[12];
                id_ex_d.alu_op    = rv_pkg::ALU_SUB;
                id_ex_d.imm       = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                use_rs2           = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                id_ex_d.reg_write  = 1'b1;
                id_ex_d.jump       = 1'b1;
                id_ex_d.result_src = rv_pkg::RES_PC_PLUS4;
                id_ex_d.imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: begin
                id_ex_d.rd = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

    assign rs1_d = rs1;
    assign rs2_d = rs2;

    a_x0_rs1: assert property (@(posedge clk) disable iff (rst)
        (id_ex.rs1 == '0) |-> (id_ex.rd1 == '0));
    a_x0_rs2: assert property (@(posedge clk) disable iff (rst)
        (id_ex.rs2 == '0) |-> (id_ex.rd2 == '0));

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::fwd_sel_e  fwd_a,
    input  rv_pkg::fwd_sel_e  fwd_b,
    input  rv_pkg::word_t     mem_fwd,
    input  rv_pkg::wb_t       wb,
    output rv_pkg::ex_mem_t   ex_mem,
    output logic              redirect,
    output rv_pkg::word_t     branch_target
);

    rv_pkg::word_t src_a;
    rv_pkg::word_t src_b_reg;
    rv_pkg::word_t alu_b;
    rv_pkg::word_t alu_result;
    logic          equal;

    function automatic rv_pkg::word_t pick(rv_pkg::fwd_sel_e sel, rv_pkg::word_t reg_val);
        case (sel)
            rv_pkg::FWD_FROM_MEM: return mem_fwd;
            rv_pkg::FWD_FROM_WB:  return wb.result;
            default:              return reg_val;
        endcase
    endfunction

    always_comb begin
        src_a     = pick(fwd_a, id_ex.rd1);
        src_b_reg = pick(fwd_b, id_ex.rd2);
    end

    assign alu_b = id_ex.alu_src ? id_ex.imm : src_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::ALU_SUB: alu_result = src_a - alu_b;
            rv_pkg::ALU_AND: alu_result = src_a & alu_b;
            rv_pkg::ALU_OR:  alu_result = src_a | alu_b;
            rv_pkg::ALU_XOR: alu_result = src_a ^ alu_b;
            default:         alu_result = src_a + alu_b;
        endcase
    end

    // beq/bne compare on forwarded operands
    assign equal         = (src_a == src_b_reg);
    assign redirect      = id_ex.jump || (id_ex.branch && (equal ^ id_ex.branch_ne));
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.result_src <= id_ex.result_src;
            ex_mem.alu_result <= alu_result;
            ex_mem.write_data <= src_b_reg;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.pc_plus4   <= id_ex.pc_plus4;
        end
    end

    // a redirect comes from a control op and leaves a bubble behind it
    a_redirect_src: assert property (@(posedge clk) disable iff (rst)
        redirect |-> (id_ex.jump || id_ex.branch)
            ##1 (!id_ex.reg_write && !id_ex.mem_write && !redirect));

endmodule

//--- verilog/fetch_stage.sv
module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  rv_pkg::word_t  instr,
    input  logic           stall_f,
    input  logic           stall_d,
    input  logic           flush_d,
    input  logic           redirect,
    input  rv_pkg::word_t  branch_target,
    output rv_pkg::word_t  pc,
    output rv_pkg::if_id_t if_id
);

    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t next_pc;

    assign pc_plus4 = pc + rv_pkg::word_t'(4);
    assign next_pc  = redirect ? branch_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!stall_f) begin
            pc <= next_pc;
        end
    end

    // all-zero instr decodes as a bubble
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            if_id <= '0;
        end else if (!stall_d) begin
            if_id.pc       <= pc;
            if_id.instr    <= instr;
            if_id.pc_plus4 <= pc_plus4;
        end
    end

endmodule

//--- verilog/hazard_unit.sv
module hazard_unit (
    input  rv_pkg::reg_addr_t rs1_d,
    input  rv_pkg::reg_addr_t rs2_d,
    input  logic              use_rs2,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::wb_t       wb,
    input  logic              redirect,
    output logic              stall_f,
    output logic              stall_d,
    output logic              flush_d,
    output logic              flush_e,
    output rv_pkg::fwd_sel_e  fwd_a,
    output rv_pkg::fwd_sel_e  fwd_b
);

    logic load_use;

    // memory stage is younger, so it wins over write-back
    function automatic rv_pkg::fwd_sel_e fwd_sel(rv_pkg::reg_addr_t rs);
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == rs) begin
            return rv_pkg::FWD_FROM_MEM;
        end
        if (wb.reg_write && wb.rd != '0 && wb.rd == rs) begin
            return rv_pkg::FWD_FROM_WB;
        end
        return rv_pkg::FWD_REGFILE;
    endfunction

    always_comb begin
        fwd_a = fwd_sel(id_ex.rs1);
        fwd_b = fwd_sel(id_ex.rs2);
    end

    // load in execute feeding the instruction in decode
    assign load_use = id_ex.mem_read && (id_ex.rd != '0) &&
                      ((id_ex.rd == rs1_d) || (use_rs2 && id_ex.rd == rs2_d));

    assign stall_f = load_use;
    assign stall_d = load_use;
    assign flush_d = redirect;
    assign flush_e = redirect || load_use;

    // a load and a control op cannot sit in execute together
    a_stall_flush: assert #0 (!(stall_d === 1'b1 && flush_d === 1'b1))
        else $error("hazard: decode stalled and flushed in the same cycle");

endmodule

//--- verilog/memory_writeback.sv
module memory_writeback (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::word_t     read_data,
    output rv_pkg::word_t     data_addr,
    output rv_pkg::word_t     din,
    output logic              data_we,
    output logic              data_re,
    output rv_pkg::word_t     mem_fwd,
    output rv_pkg::wb_t       wb,
    output logic              retire_valid,
    output rv_pkg::retire_t   retire
);

    rv_pkg::mem_wb_t mem_wb;

    // data port straight from the memory-stage register
    assign data_addr = ex_mem.alu_result;
    assign din       = ex_mem.write_data;
    assign data_we   = ex_mem.mem_write;
    assign data_re   = ex_mem.mem_read;
    assign mem_fwd   = ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write  <= ex_mem.reg_write;
            mem_wb.result_src <= ex_mem.result_src;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.read_data  <= read_data;
            mem_wb.rd         <= ex_mem.rd;
            mem_wb.pc_plus4   <= ex_mem.pc_plus4;
        end
    end

    always_comb begin
        wb.reg_write = mem_wb.reg_write;
        wb.rd        = mem_wb.rd;
        case (mem_wb.result_src)
            rv_pkg::RES_MEM:      wb.result = mem_wb.read_data;
            rv_pkg::RES_PC_PLUS4: wb.result = mem_wb.pc_plus4;
            default:              wb.result = mem_wb.alu_result;
        endcase
    end

    // trace only writes that change architectural state
    assign retire_valid = wb.reg_write && (wb.rd != '0);
    assign retire.rd    = wb.rd;
    assign retire.value = wb.result;

    a_we_re_excl: assert property (@(posedge clk) disable iff (rst)
        !(data_we && data_re));

endmodule

//--- verilog/rv_pipeline.sv
module rv_pipeline #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::word_t   instr,
    output rv_pkg::word_t   pc,
    input  rv_pkg::word_t   read_data,
    output rv_pkg::word_t   data_addr,
    output rv_pkg::word_t   din,
    output logic            data_we,
    output logic            data_re,
    output logic            retire_valid,
    output rv_pkg::retire_t retire
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::wb_t       wb;
    rv_pkg::word_t     mem_fwd;
    rv_pkg::word_t     branch_target;
    rv_pkg::reg_addr_t rs1_d;
    rv_pkg::reg_addr_t rs2_d;
    rv_pkg::fwd_sel_e  fwd_a;
    rv_pkg::fwd_sel_e  fwd_b;
    logic              use_rs2;
    logic              redirect;
    logic              stall_f;
    logic              stall_d;
    logic              flush_d;
    logic              flush_e;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) i_fetch (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .stall_f       (stall_f),
        .stall_d       (stall_d),
        .flush_d       (flush_d),
        .redirect      (redirect),
        .branch_target (branch_target),
        .pc            (pc),
        .if_id         (if_id)
    );

    decode_stage i_decode (
        .clk     (clk),
        .rst     (rst),
        .if_id   (if_id),
        .wb      (wb),
        .flush_e (flush_e),
        .id_ex   (id_ex),
        .rs1_d   (rs1_d),
        .rs2_d   (rs2_d),
        .use_rs2 (use_rs2)
    );

    execute_stage i_execute (
        .clk           (clk),
        .rst           (rst),
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_fwd       (mem_fwd),
        .wb            (wb),
        .ex_mem        (ex_mem),
        .redirect      (redirect),
        .branch_target (branch_target)
    );

    memory_writeback i_mem_wb (
        .clk          (clk),
        .rst          (rst),
        .ex_mem       (ex_mem),
        .read_data    (read_data),
        .data_addr    (data_addr),
        .din          (din),
        .data_we      (data_we),
        .data_re      (data_re),
        .mem_fwd      (mem_fwd),
        .wb           (wb),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    hazard_unit i_hazard (
        .rs1_d    (rs1_d),
        .rs2_d    (rs2_d),
        .use_rs2  (use_rs2),
        .id_ex    (id_ex),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .redirect (redirect),
        .stall_f  (stall_f),
        .stall_d  (stall_d),
        .flush_d  (flush_d),
        .flush_e  (flush_e),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

endmodule

//--- verilog/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwd_sel_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC_PLUS4
    } result_src_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        branch_ne;
        logic        jump;
        logic        alu_src;
        alu_op_e     alu_op;
        result_src_e result_src;
        word_t       rd1;
        word_t       rd2;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        word_t       imm;
        word_t       pc;
        word_t       pc_plus4;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        result_src_e result_src;
        word_t       alu_result;
        word_t       write_data;
        reg_addr_t   rd;
        word_t       pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        word_t       alu_result;
        word_t       read_data;
        reg_addr_t   rd;
        word_t       pc_plus4;
    } mem_wb_t;

    // write-back bus into the register file and the forwarding muxes
    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;
    } wb_t;

    typedef struct packed {
        reg_addr_t rd;
        word_t     value;
    } retire_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

endpackage
